// File: all.f
+incdir+logic
logic/bus_pkg.sv
logic/irq_pkg.sv
logic/cpu_bus_if.sv
logic/io_bus_map.sv
logic/irq_ctrl.sv
logic/serial_port.sv
logic/joypad.sv
logic/work_ram.sv
logic/gb_sys_top.sv
sim/gb_sys_tb.sv

// File: logic/bus_pkg.sv
// address map types: bus word types and decoded region
`include "gb_consts.svh"

package bus_pkg;

	// cpu side bus words
	typedef logic [`GB_ADDR_W-1:0] addr_t;
	typedef logic [`GB_DATA_W-1:0] data_t;

	// --------------------------------------------------
	// decoded target of one cpu address
	// --------------------------------------------------
	typedef enum logic [3:0] {
		REG_NONE  = 4'd0, // unmapped, reads ff
		REG_P1    = 4'd1, // joypad select
		REG_SB    = 4'd2, // serial data, dummy
		REG_SC    = 4'd3, // serial control
		REG_IF    = 4'd4, // interrupt flags
		REG_IE    = 4'd5, // interrupt enable
		REG_SVBK  = 4'd6, // wram bank select
		REG_ZPRAM = 4'd7, // ff80..fffe
		REG_IRAM  = 4'd8  // c000..fdfff incl. echo
	} region_e;

endpackage

// File: logic/cpu_bus_if.sv
// one cpu access plus its decoded region, shared by all units
`timescale 1ns/10ps

interface cpu_bus_if;
	import bus_pkg::*;

	addr_t   addr;   // cpu address
	data_t   wdata;  // cpu write data
	logic    rd;     // read strobe, active high
	logic    wr;     // write strobe, active high
	region_e region; // decoded by io_bus_map

	// top side, drives the raw access
	modport host (
		output addr, wdata, rd, wr
	);

	// decoder, also watches the strobes
	modport map (
		input  addr, rd, wr,
		output region
	);

	// every resource on the bus
	modport unit (
		input addr, wdata, rd, wr, region
	);

endinterface

// File: logic/gb_consts.svh
// bus widths, register addresses, fill bits, interrupt vectors
// and serial timing for the console glue
`ifndef GB_CONSTS_SVH
`define GB_CONSTS_SVH

`define GB_ADDR_W       16
`define GB_DATA_W       8

// single-word registers
`define ADDR_P1         16'hFF00
`define ADDR_SB         16'hFF01
`define ADDR_SC         16'hFF02
`define ADDR_IF         16'hFF0F
`define ADDR_SVBK       16'hFF70
`define ADDR_IE         16'hFFFF

// memory windows
`define ADDR_IRAM_LO    16'hC000 // internal ram incl. echo area
`define ADDR_IRAM_HI    16'hFE00 // first address past the echo
`define ADDR_ZP_LO      16'hFF80 // zero page up to fffe

// constant bits returned above the live register bits
`define IF_FILL         3'b111
`define IE_FILL         3'b000
`define SC_FILL         6'h3F
`define P1_FILL         2'b11
`define SVBK_FILL       5'h1F
`define UNMAPPED_DATA   8'hFF

// rst vectors put on the bus in an ack cycle
`define IRQ_VEC_VBLANK  8'h40
`define IRQ_VEC_LCD     8'h48
`define IRQ_VEC_TIMER   8'h50
`define IRQ_VEC_SERIAL  8'h58
`define IRQ_VEC_JOY     8'h60
`define IRQ_VEC_NONE    8'h55

`define SERIAL_DIV      512 // cpu clocks per bit, about 8 kHz
`define SERIAL_BITS     8

`endif

// File: logic/gb_sys_top.sv
// system glue top: cpu strobes into the shared bus, interrupt
// controller, serial, joypad and work ram
`timescale 1ns/10ps

module gb_sys_top (
	input  logic            clk_cpu,
	input  logic            reset,
	input  bus_pkg::addr_t  cpu_addr,
	input  bus_pkg::data_t  cpu_do,
	input  logic            cpu_rd_n,
	input  logic            cpu_wr_n,
	input  logic            cpu_iorq_n,
	input  logic            cpu_m1_n,
	output bus_pkg::data_t  cpu_di,
	output logic            irq_n,
	input  logic [7:0]      joystick,
	input  logic            is_gbc,
	input  logic            vblank_irq,
	input  logic            lcd_irq,
	input  logic            timer_irq
);
	import bus_pkg::*;

	data_t irq_vector;
	data_t irq_rdata;
	data_t serial_rdata;
	data_t joy_rdata;
	data_t ram_rdata;
	logic  irq_ack;
	logic  serial_irq;
	logic  joy_irq;

	// --------------------------------------------------
	// cpu bus, strobes flipped to active high
	// --------------------------------------------------
	cpu_bus_if bus ();

	assign bus.addr  = cpu_addr;
	assign bus.wdata = cpu_do;
	assign bus.rd    = !cpu_rd_n;
	assign bus.wr    = !cpu_wr_n;

	io_bus_map u_map (
		.clk_cpu      (clk_cpu),
		.reset        (reset),
		.bus          (bus.map),
		.irq_ack      (irq_ack),
		.irq_vector   (irq_vector),
		.irq_rdata    (irq_rdata),
		.serial_rdata (serial_rdata),
		.joy_rdata    (joy_rdata),
		.ram_rdata    (ram_rdata),
		.cpu_di       (cpu_di)
	);

	irq_ctrl u_irq (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus.unit),
		.cpu_iorq_n (cpu_iorq_n),
		.cpu_m1_n   (cpu_m1_n),
		.vblank_irq (vblank_irq), // from the video side
		.lcd_irq    (lcd_irq),
		.timer_irq  (timer_irq),
		.serial_irq (serial_irq),
		.joy_irq    (joy_irq),
		.irq_ack    (irq_ack),
		.irq_vector (irq_vector),
		.rdata      (irq_rdata),
		.irq_n      (irq_n)
	);

	serial_port u_serial (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus.unit),
		.rdata      (serial_rdata),
		.serial_irq (serial_irq)
	);

	joypad u_joy (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.bus      (bus.unit),
		.joystick (joystick),
		.rdata    (joy_rdata),
		.joy_irq  (joy_irq)
	);

	work_ram u_ram (
		.clk_cpu (clk_cpu),
		.reset   (reset),
		.bus     (bus.unit),
		.is_gbc  (is_gbc),
		.rdata   (ram_rdata)
	);

endmodule

// File: logic/io_bus_map.sv
// address decoder and read data mux back to the cpu
`timescale 1ns/10ps
`include "gb_consts.svh"

module io_bus_map (
	input  logic          clk_cpu,
	input  logic          reset,
	cpu_bus_if.map        bus,
	input  logic          irq_ack,
	input  bus_pkg::data_t irq_vector,
	input  bus_pkg::data_t irq_rdata,
	input  bus_pkg::data_t serial_rdata,
	input  bus_pkg::data_t joy_rdata,
	input  bus_pkg::data_t ram_rdata,
	output bus_pkg::data_t cpu_di
);
	import bus_pkg::*;

	region_e reg_sel;

	// --------------------------------------------------
	// decode, single registers before the windows
	// --------------------------------------------------
	always_comb begin
		if (bus.addr == `ADDR_P1)        reg_sel = REG_P1;
		else if (bus.addr == `ADDR_SB)   reg_sel = REG_SB;
		else if (bus.addr == `ADDR_SC)   reg_sel = REG_SC;
		else if (bus.addr == `ADDR_IF)   reg_sel = REG_IF;
		else if (bus.addr == `ADDR_SVBK) reg_sel = REG_SVBK;
		else if (bus.addr == `ADDR_IE)   reg_sel = REG_IE; // ffff, not zero page
		else if (bus.addr >= `ADDR_ZP_LO) reg_sel = REG_ZPRAM;
		else if (bus.addr >= `ADDR_IRAM_LO && bus.addr < `ADDR_IRAM_HI)
			reg_sel = REG_IRAM;
		else
			reg_sel = REG_NONE;
	end

	assign bus.region = reg_sel;

	// read mux, ack vector has priority over everything
	always_comb begin
		if (irq_ack) begin
			cpu_di = irq_vector;
		end else begin
			case (reg_sel)
				REG_P1:                     cpu_di = joy_rdata;
				REG_SC:                     cpu_di = serial_rdata;
				REG_IF, REG_IE:             cpu_di = irq_rdata;
				REG_SVBK, REG_ZPRAM, REG_IRAM: cpu_di = ram_rdata;
				default:                    cpu_di = `UNMAPPED_DATA; // sb and holes
			endcase
		end
	end

	// cpu never strobes both directions
	a_rd_wr_excl: assert property (@(posedge clk_cpu) disable iff (reset)
		!(bus.rd && bus.wr));

endmodule

// File: logic/irq_ctrl.sv
// interrupt controller: IE/IF registers, priority vector,
// ack end flag clear and irq_n
`timescale 1ns/10ps
`include "gb_consts.svh"

module irq_ctrl (
	input  logic           clk_cpu,
	input  logic           reset,
	cpu_bus_if.unit        bus,
	input  logic           cpu_iorq_n,
	input  logic           cpu_m1_n,
	input  logic           vblank_irq,
	input  logic           lcd_irq,
	input  logic           timer_irq,
	input  logic           serial_irq,
	input  logic           joy_irq,
	output logic           irq_ack,
	output bus_pkg::data_t irq_vector,
	output bus_pkg::data_t rdata,
	output logic           irq_n
);
	import bus_pkg::*;
	import irq_pkg::*;

	irq_vec_t ie_r, if_r;
	irq_vec_t events, pending, winner, if_next;
	logic     old_ack;  // ack delayed one cycle
	logic     ack_end;
	logic     if_wr;

	assign irq_ack = !cpu_iorq_n && !cpu_m1_n; // int ack cycle
	assign ack_end = old_ack && !irq_ack;
	assign if_wr   = bus.wr && bus.region == REG_IF;

	always_comb begin
		events         = '0;
		events[VBLANK] = vblank_irq;
		events[LCD]    = lcd_irq;
		events[TIMER]  = timer_irq;
		events[SERIAL] = serial_irq;
		events[JOY]    = joy_irq;
	end

	assign pending = ie_r & if_r;
	assign winner  = pending & (~pending + 5'd1); // lowest set bit only
	assign irq_n   = ~|pending;

	// --------------------------------------------------
	// vector for the ack cycle
	// --------------------------------------------------
	always_comb begin
		if (pending[VBLANK])      irq_vector = `IRQ_VEC_VBLANK;
		else if (pending[LCD])    irq_vector = `IRQ_VEC_LCD;
		else if (pending[TIMER])  irq_vector = `IRQ_VEC_TIMER;
		else if (pending[SERIAL]) irq_vector = `IRQ_VEC_SERIAL;
		else if (pending[JOY])    irq_vector = `IRQ_VEC_JOY;
		else                      irq_vector = `IRQ_VEC_NONE;
	end

	// events set, ack end clears winner, cpu write overrides both
	always_comb begin
		if_next = if_r | events;
		if (ack_end)
			if_next = if_next & ~winner;
		if (if_wr)
			if_next = bus.wdata[4:0];
	end

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			ie_r    <= '0;
			if_r    <= '0;
			old_ack <= 1'b0;
		end else begin
			old_ack <= irq_ack;
			if_r    <= if_next;
			if (bus.wr && bus.region == REG_IE)
				ie_r <= bus.wdata[4:0];
		end
	end

	assign rdata = (bus.region == REG_IF) ? {`IF_FILL, if_r} : {`IE_FILL, ie_r};

	// an ack end drops one flag at most
	a_one_clear: assert property (@(posedge clk_cpu) disable iff (reset)
		(ack_end && !if_wr) |=> ($countones($past(if_r) & ~if_r) <= 1));

endmodule

// File: logic/irq_pkg.sv
// interrupt types: source numbering and flag vector

package irq_pkg;

	// bit position in IE/IF, lowest number wins
	typedef enum logic [2:0] {
		VBLANK = 3'd0,
		LCD    = 3'd1, // lcd stat
		TIMER  = 3'd2,
		SERIAL = 3'd3,
		JOY    = 3'd4  // joypad line falling
	} irq_src_e;

	// one flag per source
	typedef logic [4:0] irq_vec_t;

endpackage

// File: logic/joypad.sv
// joypad P1 select register, key matrix read, falling edge irq
`timescale 1ns/10ps
`include "gb_consts.svh"

module joypad (
	input  logic           clk_cpu,
	input  logic           reset,
	cpu_bus_if.unit        bus,
	input  logic [7:0]     joystick,
	output bus_pkg::data_t rdata,
	output logic           joy_irq
);
	import bus_pkg::*;

	logic [1:0] p54;        // select bits 5:4, low selects
	logic [3:0] joy_p4;     // directions, low = pressed
	logic [3:0] joy_p5;     // buttons
	logic [7:0] lines_d;    // first delay stage
	logic [7:0] lines_d2;   // second delay stage

	// keys are active high on the port, inverted for the matrix
	assign joy_p4 = ~{joystick[2], joystick[3], joystick[1], joystick[0]} | {4{p54[0]}};
	assign joy_p5 = ~{joystick[7], joystick[6], joystick[5], joystick[4]} | {4{p54[1]}};

	assign rdata = {`P1_FILL, p54, joy_p4 & joy_p5};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54      <= 2'b00;
			lines_d  <= 8'hFF; // all released
			lines_d2 <= 8'hFF;
			joy_irq  <= 1'b0;
		end else begin
			if (bus.wr && bus.region == REG_P1)
				p54 <= bus.wdata[5:4];
			lines_d  <= {joy_p4, joy_p5};
			lines_d2 <= lines_d;
			joy_irq  <= |(~lines_d & lines_d2); // any line went low
		end
	end

endmodule

// File: logic/serial_port.sv
// dummy serial port: SC register, bit timer and done interrupt
`timescale 1ns/10ps
`include "gb_consts.svh"

module serial_port (
	input  logic           clk_cpu,
	input  logic           reset,
	cpu_bus_if.unit        bus,
	output bus_pkg::data_t rdata,
	output logic           serial_irq
);
	import bus_pkg::*;

	localparam int DIV_W = $clog2(`SERIAL_DIV);
	localparam int CNT_W = $clog2(`SERIAL_BITS + 1);

	logic             sc_start;      // transfer running
	logic             sc_shiftclock; // internal clock select
	logic [DIV_W-1:0] clk_div;       // one bit period
	logic [CNT_W-1:0] bit_cnt;       // bits left

	// --------------------------------------------------
	// no data moves, the transfer only times out
	// --------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			sc_start      <= 1'b0;
			sc_shiftclock <= 1'b0;
			serial_irq    <= 1'b0;
			clk_div       <= '0;
			bit_cnt       <= '0;
		end else begin
			serial_irq <= 1'b0; // one cycle strobe
			if (bus.wr && bus.region == REG_SC) begin
				sc_start      <= bus.wdata[7];
				sc_shiftclock <= bus.wdata[0];
				if (bus.wdata[7]) begin // start bit, arm timer
					clk_div <= DIV_W'(`SERIAL_DIV - 1);
					bit_cnt <= CNT_W'(`SERIAL_BITS);
				end
			end else if (sc_start && sc_shiftclock) begin
				clk_div <= clk_div - 1'b1; // wraps to full period
				if (clk_div == '0 && bit_cnt != '0)
					bit_cnt <= bit_cnt - 1'b1;
				if (bit_cnt == '0) begin
					serial_irq <= 1'b1;
					sc_start   <= 1'b0; // transfer done
					clk_div    <= DIV_W'(`SERIAL_DIV - 1);
					bit_cnt    <= CNT_W'(`SERIAL_BITS);
				end
			end
		end
	end

	assign rdata = {sc_start, `SC_FILL, sc_shiftclock};

	a_bit_cnt_range: assert property (@(posedge clk_cpu) disable iff (reset)
		bit_cnt <= `SERIAL_BITS);

endmodule

// File: logic/work_ram.sv
// zero page ram, banked 32k internal ram and the SVBK register
`timescale 1ns/10ps
`include "gb_consts.svh"

module work_ram (
	input  logic           clk_cpu,
	input  logic           reset,
	cpu_bus_if.unit        bus,
	input  logic           is_gbc,
	output bus_pkg::data_t rdata
);
	import bus_pkg::*;

	data_t       zp_mem   [0:127];   // ff80..fffe, top byte is IE
	data_t       iram_mem [0:32767]; // 8 banks of 4k
	data_t       zp_q;
	data_t       iram_q;
	logic [2:0]  iram_bank;          // 1..7
	logic [14:0] iram_addr;

	// d000 half switches, c000 half fixed to bank 0
	assign iram_addr = bus.addr[12] ? {iram_bank, bus.addr[11:0]} :
		{3'd0, bus.addr[11:0]};

	// --------------------------------------------------
	// sync ram, one cycle read latency
	// --------------------------------------------------
	always_ff @(posedge clk_cpu) begin
		if (bus.wr && bus.region == REG_ZPRAM)
			zp_mem[bus.addr[6:0]] <= bus.wdata;
		if (bus.rd && bus.region == REG_ZPRAM)
			zp_q <= zp_mem[bus.addr[6:0]];
		if (bus.wr && bus.region == REG_IRAM)
			iram_mem[iram_addr] <= bus.wdata;
		if (bus.rd && bus.region == REG_IRAM)
			iram_q <= iram_mem[iram_addr];
	end

	// color model only, bank 0 selects 1
	always_ff @(posedge clk_cpu) begin
		if (reset)
			iram_bank <= 3'd1;
		else if (bus.wr && bus.region == REG_SVBK && is_gbc)
			iram_bank <= (bus.wdata[2:0] == 3'd0) ? 3'd1 : bus.wdata[2:0];
	end

	always_comb begin
		case (bus.region)
			REG_SVBK:  rdata = {`SVBK_FILL, iram_bank};
			REG_ZPRAM: rdata = zp_q;
			default:   rdata = iram_q; // address held for the access
		endcase
	end

endmodule

// File: run_sim.sh
#!/bin/sh
# build the console glue testbench with Verilator, run it, check the log
cd "$(dirname "$0")" || exit 1

TOP=gb_sys_tb
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal --top-module "$TOP" -f all.f
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

./obj_dir/V$TOP > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "Simulation completed successfully" "$LOG"; then
	echo "PASS"
	exit 0
fi

echo "FAIL"
exit 1

// File: sim/gb_sys_tb.sv
// testbench for the console glue: bus tasks, LCG stimulus,
// assertions, watchdog and result line
`timescale 1ns/10ps
`include "gb_consts.svh"

module gb_sys_tb;
	import bus_pkg::*;

	localparam int CLK_HALF       = 4; // 8 ns period
	localparam int SERIAL_LIMIT   = `SERIAL_BITS * `SERIAL_DIV + 4;
	localparam int TIMEOUT_CYCLES = 4 * SERIAL_LIMIT + 4000; // serial wait plus margin

	logic       clk_cpu;
	logic       reset;
	addr_t      cpu_addr;
	data_t      cpu_do;
	logic       cpu_rd_n;
	logic       cpu_wr_n;
	logic       cpu_iorq_n;
	logic       cpu_m1_n;
	data_t      cpu_di;
	logic       irq_n;
	logic [7:0] joystick;
	logic       is_gbc;
	logic       vblank_irq;
	logic       lcd_irq;
	logic       timer_irq;

	int          checks;
	int          errors;     // immediate compares
	int          sva_errors; // concurrent properties
	logic [31:0] lcg_state;

	gb_sys_top dut0 (.*);

	initial begin
		clk_cpu = 1'b0;
		forever #CLK_HALF clk_cpu = ~clk_cpu;
	end

	// --------------------------------------------------
	// helpers, all start and end just after a negedge
	// --------------------------------------------------
	function automatic data_t lcg_byte();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state[23:16]; // upper bits, better spread
	endfunction

	task automatic check_eq(input string name, input data_t got, input data_t exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("FAILED %s: got %h expected %h", name, got, exp);
		end
	endtask

	task automatic bus_write(input addr_t a, input data_t d);
		cpu_addr = a;
		cpu_do   = d;
		cpu_wr_n = 1'b0;
		@(negedge clk_cpu); // write lands on the edge in between
		cpu_wr_n = 1'b1;
	endtask

	// two cycle read, sampled after the first edge
	task automatic bus_read(input addr_t a, output data_t d);
		cpu_addr = a;
		cpu_rd_n = 1'b0;
		@(negedge clk_cpu);
		d = cpu_di;
		@(negedge clk_cpu);
		cpu_rd_n = 1'b1;
	endtask

	task automatic read_check(input addr_t a, input data_t exp, input string name);
		data_t d;
		bus_read(a, d);
		check_eq(name, d, exp);
	endtask

	// ack over one edge, then one edge for the flag clear
	task automatic ack_cycle(output data_t vec);
		cpu_iorq_n = 1'b0;
		cpu_m1_n   = 1'b0;
		@(negedge clk_cpu);
		vec        = cpu_di;
		cpu_iorq_n = 1'b1;
		cpu_m1_n   = 1'b1;
		@(negedge clk_cpu);
	endtask

	// hold a read of IF and poll one bit
	task automatic wait_if_bit(input int bit_no, input int limit, input string what);
		int   n;
		logic found;
		n        = 0;
		found    = 1'b0;
		cpu_addr = `ADDR_IF;
		cpu_rd_n = 1'b0;
		while (!found && n < limit) begin
			@(negedge clk_cpu);
			n++;
			found = cpu_di[bit_no];
		end
		cpu_rd_n = 1'b1;
		checks++;
		assert (found) else begin
			errors++;
			$display("%s did not set IF bit %0d within %0d cycles", what, bit_no, limit);
		end
	endtask

	// --------------------------------------------------
	// test sequences
	// --------------------------------------------------
	task automatic ram_sequence();
		data_t r;
		data_t r2;
		data_t d;
		data_t bank;
		addr_t a;
		for (int i = 0; i < 8; i++) begin
			a = `ADDR_ZP_LO + addr_t'(lcg_byte() % 8'd127); // ff80..fffe
			d = lcg_byte();
			bus_write(a, d);
			read_check(a, d, "cpu_di zpram");
			r  = lcg_byte();
			r2 = lcg_byte();
			a  = {4'hC, r[3:0], r2};
			d  = lcg_byte();
			bus_write(a, d);
			read_check(a, d, "cpu_di bank0");
			bank = (lcg_byte() % 8'd7) + 8'd1;
			bus_write(`ADDR_SVBK, bank);
			read_check(`ADDR_SVBK, {5'h1F, bank[2:0]}, "cpu_di svbk");
			a = {4'hD, r2[3:0], r};
			d = lcg_byte();
			bus_write(a, d);
			read_check(a, d, "cpu_di bank n");
		end
		// same d-address, two banks
		bus_write(`ADDR_SVBK, 8'h01);
		bus_write(16'hD040, 8'hA5);
		bus_write(`ADDR_SVBK, 8'h03);
		bus_write(16'hD040, 8'h3C);
		read_check(16'hD040, 8'h3C, "cpu_di bank3");
		bus_write(`ADDR_SVBK, 8'h01);
		read_check(16'hD040, 8'hA5, "cpu_di bank1");
		// echo area
		bus_write(16'hE123, 8'h5A);
		read_check(16'hC123, 8'h5A, "cpu_di echo");
		bus_write(`ADDR_SVBK, 8'h06); // move off bank 1 first
		bus_write(`ADDR_SVBK, 8'h00);
		read_check(`ADDR_SVBK, 8'hF9, "cpu_di svbk zero");
		is_gbc = 1'b0; // mono model ignores svbk
		bus_write(`ADDR_SVBK, 8'h05);
		read_check(`ADDR_SVBK, 8'hF9, "cpu_di svbk mono");
		is_gbc = 1'b1;
	endtask

	task automatic interrupt_sequence();
		data_t vec;
		bus_write(`ADDR_IE, 8'h05);
		bus_write(`ADDR_IF, 8'h00);
		vblank_irq = 1'b1;
		timer_irq  = 1'b1;
		@(negedge clk_cpu);
		vblank_irq = 1'b0;
		timer_irq  = 1'b0;
		check_eq("irq_n", data_t'(irq_n), 8'h00);
		ack_cycle(vec);
		check_eq("cpu_di ack vblank", vec, 8'h40);
		read_check(`ADDR_IF, 8'hE4, "cpu_di if");
		ack_cycle(vec);
		check_eq("cpu_di ack timer", vec, 8'h50);
		read_check(`ADDR_IF, 8'hE0, "cpu_di if");
		ack_cycle(vec);
		check_eq("cpu_di ack none", vec, 8'h55);
		check_eq("irq_n", data_t'(irq_n), 8'h01);
	endtask

	task automatic register_reads();
		read_check(`ADDR_IE, 8'h05, "cpu_di ie");
		bus_write(`ADDR_IF, 8'h0A);
		read_check(`ADDR_IF, 8'hEA, "cpu_di if");
		bus_write(`ADDR_IF, 8'h00);
		read_check(`ADDR_SB, 8'hFF, "cpu_di sb");
		read_check(16'hFF03, 8'hFF, "cpu_di ff03");
		read_check(16'h8000, 8'hFF, "cpu_di 8000");
	endtask

	task automatic joypad_sequence();
		logic [7:0] j;
		bus_write(`ADDR_P1, 8'h20); // directions selected
		for (int i = 0; i < 4; i++) begin
			j        = lcg_byte();
			joystick = j;
			read_check(`ADDR_P1, {4'b1110, ~{j[2], j[3], j[1], j[0]}}, "cpu_di p1 dir");
		end
		bus_write(`ADDR_P1, 8'h10); // buttons
		j        = lcg_byte();
		joystick = j;
		read_check(`ADDR_P1, {4'b1101, ~{j[7], j[6], j[5], j[4]}}, "cpu_di p1 btn");
		bus_write(`ADDR_P1, 8'h20);
		joystick = 8'h00; // all released
		repeat (4) @(negedge clk_cpu);
		bus_write(`ADDR_IF, 8'h00);
		joystick = 8'h04; // press up
		wait_if_bit(4, 3, "joypad press");
	endtask

	task automatic serial_sequence();
		bus_write(`ADDR_IF, 8'h00);
		bus_write(`ADDR_SC, 8'h81);
		read_check(`ADDR_SC, 8'hFF, "cpu_di sc");
		wait_if_bit(3, SERIAL_LIMIT - 2, "serial transfer"); // read used 2 cycles
		read_check(`ADDR_SC, 8'h7F, "cpu_di sc done");
	endtask

	// --------------------------------------------------
	// concurrent checks
	// --------------------------------------------------
	a_reset_idle: assert property (@(posedge clk_cpu) $fell(reset) |-> irq_n)
		else begin
			sva_errors++;
			$display("FAILED irq_n: got %h expected %h", $sampled(irq_n), 1'b1);
		end

	a_ack_none: assert property (@(posedge clk_cpu) disable iff (reset)
		(!cpu_iorq_n && !cpu_m1_n && irq_n) |-> cpu_di == 8'h55)
		else begin
			sva_errors++;
			$display("FAILED cpu_di: got %h expected %h", $sampled(cpu_di), 8'h55);
		end

	a_ack_vector: assert property (@(posedge clk_cpu) disable iff (reset)
		(!cpu_iorq_n && !cpu_m1_n && !irq_n) |->
		cpu_di inside {8'h40, 8'h48, 8'h50, 8'h58, 8'h60})
		else begin
			sva_errors++;
			$display("FAILED cpu_di: got %h expected one of 40 48 50 58 60",
				$sampled(cpu_di));
		end

	initial begin : watchdog
		repeat (TIMEOUT_CYCLES) @(posedge clk_cpu);
		$display("timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

	initial begin
		reset      = 1'b1;
		cpu_addr   = '0;
		cpu_do     = '0;
		cpu_rd_n   = 1'b1;
		cpu_wr_n   = 1'b1;
		cpu_iorq_n = 1'b1;
		cpu_m1_n   = 1'b1;
		joystick   = 8'h00;
		is_gbc     = 1'b1;
		vblank_irq = 1'b0;
		lcd_irq    = 1'b0;
		timer_irq  = 1'b0;
		checks     = 0;
		errors     = 0;
		sva_errors = 0;
		lcg_state  = 32'd16902;
		repeat (10) @(negedge clk_cpu);
		reset = 1'b0;
		@(negedge clk_cpu);
		ram_sequence();
		interrupt_sequence();
		register_reads();
		joypad_sequence();
		serial_sequence();
		repeat (2) @(negedge clk_cpu);
		$display("checks %0d, compare errors %0d, assertion errors %0d",
			checks, errors, sva_errors);
		if (errors == 0 && sva_errors == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule
